// File: files.f
+incdir+sim
design/img_pkg.sv
design/pixel_counter.sv
design/box_tracker.sv
design/overlay_mixer.sv
design/msg_writer.sv
design/msg_fifo.sv
design/mm_regs.sv
design/img_proc_top.sv
sim/tb_img_proc.sv

// File: Bender.yml
package:
  name: img_proc

sources:
  - design/img_pkg.sv
  - design/pixel_counter.sv
  - design/box_tracker.sv
  - design/overlay_mixer.sv
  - design/msg_writer.sv
  - design/msg_fifo.sv
  - design/mm_regs.sv
  - design/img_proc_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_img_proc.sv

// File: sim/tb_frames.svh
// 32-bit LCG step with the usual Numerical Recipes constants
function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// drive one beat and hold it until the DUT takes it
task automatic send_beat(input pixel_t data, input logic sop, input logic eop,
                         input pixel_t expected);
    logic taken;
    taken = 1'b0;
    sink_data  <= data;
    sink_sop   <= sop;
    sink_eop   <= eop;
    sink_valid <= 1'b1;
    while (!taken) begin
        @(negedge clk);
        taken = sink_ready;
        @(posedge clk);
    end
    exp_q.push_back({sop, eop, expected});
endtask

// message model run once per finished video frame
task automatic model_frame_end(input int count);
    if (m_cnt == 0 && msg_q.size() <= FIFO_DEPTH - MSG_LEN) begin
        msg_q.push_back(ID_WORD);
        msg_q.push_back({5'b0, 11'((m_left + m_right) / 2),
                         5'b0, 11'((m_top + m_bottom) / 2)});
        msg_q.push_back({5'b0, 11'(m_bottom - m_top), 5'b0, 11'(m_right - m_left)});
        msg_q.push_back(word_t'(count));
        m_cnt = MSG_INTERVAL - 1;
    end else if (m_cnt != 0) begin
        m_cnt--;
    end
endtask

// descriptor then n_pixels beats; video packets update the box model
task automatic send_packet(input logic video, input int n_pixels);
    logic [31:0] r;
    pixel_t      desc, pix, shown;
    logic [7:0]  red, green, blue, max_ch;
    logic [7:0]  grey;
    logic        bright;
    int          px, py;
    int          f_left, f_right, f_top, f_bottom, f_count;
    f_left    = IMAGE_W - 1;
    f_right   = 0;
    f_top     = IMAGE_H - 1;
    f_bottom  = 0;
    f_count   = 0;
    pix_state = lcg_step(pix_state);
    desc      = pix_state[23:0];
    // low nibble of blue tells video from other packets
    desc[3:0] = video ? 4'h0 : (pix_state[3:0] | 4'h1);
    @(posedge clk);
    send_beat(desc, 1'b1, 1'b0, desc);
    for (int i = 0; i < n_pixels; i++) begin
        pix_state = lcg_step(pix_state);
        r         = pix_state;
        // mostly dark with now and then one bright channel
        pix = r[23:0] & 24'h7f7f7f;
        if (r[31:30] != 2'b11 && r[29:27] == 3'd0) begin
            pix[8 * r[31:30] + 7] = 1'b1;
        end
        px     = i % IMAGE_W;
        py     = i / IMAGE_W;
        red    = pix[23:16];
        green  = pix[15:8];
        blue   = pix[7:0];
        // bright when the largest channel has bit 7 set
        max_ch = (red > green) ? red : green;
        max_ch = (blue > max_ch) ? blue : max_ch;
        bright = max_ch[7];
        grey   = green / 8'd2 + red / 8'd4 + blue / 8'd4;
        shown  = pix;
        if (video && overlay_mode) begin
            if (px == m_left || px == m_right || py == m_top || py == m_bottom) begin
                shown = m_bbcol;
            end else if (bright) begin
                shown = RED;
            end else begin
                shown = {grey, grey, grey};
            end
        end
        if (video && bright) begin
            f_left   = (px < f_left) ? px : f_left;
            f_right  = (px > f_right) ? px : f_right;
            f_top    = (py < f_top) ? py : f_top;
            f_bottom = (py > f_bottom) ? py : f_bottom;
            f_count++;
        end
        send_beat(pix, 1'b0, i == n_pixels - 1, shown);
    end
    sink_valid <= 1'b0;
    sink_sop   <= 1'b0;
    sink_eop   <= 1'b0;
    if (video) begin
        m_left   = f_left;
        m_right  = f_right;
        m_top    = f_top;
        m_bottom = f_bottom;
        model_frame_end(f_count);
        // writer emits its four words in the cycles after frame end
        repeat (MSG_LEN + 1) @(posedge clk);
    end
endtask

// File: sim/tb_img_proc.sv
`timescale 1ns/1ns

module tb_img_proc
    import img_pkg::*;
();

    localparam int IMAGE_W         = 16;
    localparam int IMAGE_H         = 8;
    localparam int MSG_INTERVAL    = 2;
    localparam int FIFO_DEPTH      = 15;
    localparam int PIXELS          = IMAGE_W * IMAGE_H;
    localparam int MSG_LEN         = 4;
    localparam int NUM_PACKETS     = 17;
    localparam int WATCHDOG_CYCLES = NUM_PACKETS * (PIXELS + 1) * 4 + 2000;
    localparam int DRAIN_LIMIT     = 200;
    localparam logic [31:0] SEED   = 32'h70e6598c;

    // reference values
    localparam word_t  ID_WORD = {8'h00, "RBB"};
    localparam word_t  DEV_ID  = 32'h1234_EEE2;
    localparam pixel_t GREEN   = 24'h00ff00;
    localparam pixel_t RED     = 24'hff0000;

    logic      clk;
    logic      reset_n;
    pixel_t    sink_data;
    logic      sink_valid, sink_sop, sink_eop, sink_ready;
    pixel_t    source_data;
    logic      source_valid, source_sop, source_eop, source_ready;
    logic      overlay_mode;
    logic      s_chipselect, s_read, s_write;
    reg_addr_t s_address;
    word_t     s_writedata, s_readdata;

    logic [31:0] pix_state = SEED;
    logic [31:0] rdy_state = ~SEED;
    logic [25:0] exp_q[$];
    logic [25:0] exp_beat;
    word_t       msg_q[$];
    int          m_left, m_right, m_top, m_bottom, m_cnt;
    pixel_t      m_bbcol;
    int          errors = 0;
    int          checks = 0;
    string       test_name = "reset";

    img_proc_top #(
        .IMAGE_W      (IMAGE_W),
        .IMAGE_H      (IMAGE_H),
        .MSG_INTERVAL (MSG_INTERVAL),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) DUT (
        .clk          (clk),
        .reset_n      (reset_n),
        .sink_data    (sink_data),
        .sink_valid   (sink_valid),
        .sink_sop     (sink_sop),
        .sink_eop     (sink_eop),
        .sink_ready   (sink_ready),
        .source_data  (source_data),
        .source_valid (source_valid),
        .source_sop   (source_sop),
        .source_eop   (source_eop),
        .source_ready (source_ready),
        .overlay_mode (overlay_mode),
        .s_chipselect (s_chipselect),
        .s_read       (s_read),
        .s_write      (s_write),
        .s_address    (s_address),
        .s_writedata  (s_writedata),
        .s_readdata   (s_readdata)
    );

    `include "tb_frames.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the test sequence finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("ERROR %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    // a held output beat must stay valid and unchanged
    assert property (@(posedge clk) disable iff (!reset_n)
        source_valid && !source_ready |=> source_valid)
    else begin
        errors++;
        $display("source_valid dropped while source_ready was low");
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        source_valid && !source_ready |=> $stable({source_sop, source_eop, source_data}))
    else begin
        errors++;
        $display("held output beat changed while source_ready was low");
    end

    // random back-pressure
    always @(posedge clk) begin
        rdy_state = lcg_step(rdy_state);
        source_ready <= (rdy_state[31:30] != 2'b00);
    end

    // output scoreboard, beat transfers at the following rising edge
    always @(negedge clk) begin
        if (reset_n && source_valid && source_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("output beat appeared with no input beat behind it");
            end else begin
                exp_beat = exp_q.pop_front();
                check_word(test_name, word_t'(exp_beat),
                           word_t'({source_sop, source_eop, source_data}));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // host port and sequence helpers

    task automatic host_read(input reg_addr_t addr, output word_t data);
        @(posedge clk);
        s_chipselect <= 1'b1;
        s_read       <= 1'b1;
        s_address    <= addr;
        @(posedge clk);
        s_chipselect <= 1'b0;
        s_read       <= 1'b0;
        @(negedge clk);
        data = s_readdata;
    endtask

    task automatic host_write(input reg_addr_t addr, input word_t data);
        @(posedge clk);
        s_chipselect <= 1'b1;
        s_write      <= 1'b1;
        s_address    <= addr;
        s_writedata  <= data;
        @(posedge clk);
        s_chipselect <= 1'b0;
        s_write      <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("output stream stalled with %0d beats still missing", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic check_level();
        word_t d;
        host_read(ADDR_STATUS, d);
        check_word({test_name, " level"}, word_t'(msg_q.size()), word_t'(d[15:8]));
    endtask

    task automatic run_frame();
        send_packet(1'b1, PIXELS);
        wait_drain();
        check_level();
    endtask

    task automatic read_message();
        word_t d;
        for (int k = 0; k < MSG_LEN; k++) begin
            host_read(ADDR_MSG, d);
            if (msg_q.size() == 0) begin
                errors++;
                $display("message read while the model holds no message");
            end else begin
                check_word($sformatf("%s word %0d", test_name, k), msg_q.pop_front(), d);
            end
            check_level();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        word_t d;
        reset_n      = 1'b0;
        sink_data    = '0;
        sink_valid   = 1'b0;
        sink_sop     = 1'b0;
        sink_eop     = 1'b0;
        source_ready = 1'b0;
        overlay_mode = 1'b0;
        s_chipselect = 1'b0;
        s_read       = 1'b0;
        s_write      = 1'b0;
        s_address    = '0;
        s_writedata  = '0;
        // box and writer state as after reset
        m_left   = IMAGE_W - 1;
        m_right  = 0;
        m_top    = IMAGE_H - 1;
        m_bottom = 0;
        m_cnt    = 0;
        m_bbcol  = GREEN;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        test_name = "registers";
        host_read(ADDR_ID, d);
        check_word("device id", DEV_ID, d);
        host_read(ADDR_BBCOL, d);
        check_word("bbcol default", word_t'(GREEN), d);

        test_name = "pass-through";
        run_frame();
        send_packet(1'b0, 5);
        wait_drain();
        run_frame();
        test_name = "messages";
        read_message();

        test_name = "overlay";
        @(posedge clk);
        overlay_mode <= 1'b1;
        run_frame();
        send_packet(1'b0, 5);
        wait_drain();
        run_frame();
        read_message();

        test_name = "bbcol overlay";
        host_write(ADDR_BBCOL, 32'h0024_68ac);
        m_bbcol = 24'h2468ac;
        host_read(ADDR_BBCOL, d);
        check_word("bbcol written", 32'h0024_68ac, d);
        run_frame();
        run_frame();
        read_message();

        // fill to 12 words, then the writer must hold off
        test_name = "fifo room";
        for (int n = 0; n < 8; n++) begin
            run_frame();
        end
        test_name = "flush";
        host_write(ADDR_STATUS, word_t'(1) << FLUSH_BIT);
        msg_q.delete();
        check_level();
        run_frame();
        read_message();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: design/img_proc_top.sv
`timescale 1ns/1ns

module img_proc_top
    import img_pkg::*;
#(
    parameter int IMAGE_W      = 640,
    parameter int IMAGE_H      = 480,
    parameter int MSG_INTERVAL = 30,
    parameter int FIFO_DEPTH   = 255
) (
    input  logic      clk,
    input  logic      reset_n,
    input  pixel_t    sink_data,
    input  logic      sink_valid,
    input  logic      sink_sop,
    input  logic      sink_eop,
    output logic      sink_ready,
    output pixel_t    source_data,
    output logic      source_valid,
    output logic      source_sop,
    output logic      source_eop,
    input  logic      source_ready,
    input  logic      overlay_mode,
    input  logic      s_chipselect,
    input  logic      s_read,
    input  logic      s_write,
    input  reg_addr_t s_address,
    input  word_t     s_writedata,
    output word_t     s_readdata
);

    logic        accept;
    coord_t      x, y;
    logic        video_pkt;
    logic        pixel_en, frame_end, bright;
    coord_t      left, right, top, bottom;
    count_t      bright_count;
    pixel_t      bb_col;
    logic        fifo_wr, fifo_rd, fifo_flush, fifo_empty;
    word_t       fifo_data, fifo_head;
    fifo_level_t fifo_level;

    assign accept = sink_valid & sink_ready;

    ////////////////////////////////////////////////////////////////////////////
    // stream path

    pixel_counter #(
        .IMAGE_W (IMAGE_W)
    ) u_pixel_counter (
        .clk             (clk),
        .reset_n         (reset_n),
        .accept          (accept),
        .sop             (sink_sop),
        .eop             (sink_eop),
        .descriptor_blue (sink_data[7:0]),
        .x               (x),
        .y               (y),
        .video_pkt       (video_pkt),
        .pixel_en        (pixel_en),
        .frame_end       (frame_end)
    );

    overlay_mixer u_overlay_mixer (
        .clk          (clk),
        .reset_n      (reset_n),
        .sink_data    (sink_data),
        .sink_valid   (sink_valid),
        .sink_sop     (sink_sop),
        .sink_eop     (sink_eop),
        .overlay_mode (overlay_mode & video_pkt),
        .pixel_en     (pixel_en),
        .x            (x),
        .y            (y),
        .left         (left),
        .right        (right),
        .top          (top),
        .bottom       (bottom),
        .bb_col       (bb_col),
        .bright       (bright),
        .sink_ready   (sink_ready),
        .source_data  (source_data),
        .source_valid (source_valid),
        .source_sop   (source_sop),
        .source_eop   (source_eop),
        .source_ready (source_ready)
    );

    box_tracker #(
        .IMAGE_W (IMAGE_W),
        .IMAGE_H (IMAGE_H)
    ) u_box_tracker (
        .clk          (clk),
        .reset_n      (reset_n),
        .accept       (accept),
        .sop          (sink_sop),
        .pixel_en     (pixel_en),
        .bright       (bright),
        .frame_end    (frame_end),
        .x            (x),
        .y            (y),
        .left         (left),
        .right        (right),
        .top          (top),
        .bottom       (bottom),
        .bright_count (bright_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // messages and host port

    msg_writer #(
        .MSG_INTERVAL (MSG_INTERVAL),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_msg_writer (
        .clk          (clk),
        .reset_n      (reset_n),
        .frame_end    (frame_end),
        .left         (left),
        .right        (right),
        .top          (top),
        .bottom       (bottom),
        .bright_count (bright_count),
        .fifo_level   (fifo_level),
        .fifo_wr      (fifo_wr),
        .fifo_data    (fifo_data)
    );

    msg_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_msg_fifo (
        .clk     (clk),
        .reset_n (reset_n),
        .flush   (fifo_flush),
        .wr      (fifo_wr),
        .rd      (fifo_rd),
        .wr_data (fifo_data),
        .head    (fifo_head),
        .level   (fifo_level),
        .empty   (fifo_empty)
    );

    mm_regs u_mm_regs (
        .clk          (clk),
        .reset_n      (reset_n),
        .s_chipselect (s_chipselect),
        .s_read       (s_read),
        .s_write      (s_write),
        .s_address    (s_address),
        .s_writedata  (s_writedata),
        .s_readdata   (s_readdata),
        .fifo_head    (fifo_head),
        .fifo_level   (fifo_level),
        .fifo_empty   (fifo_empty),
        .fifo_rd      (fifo_rd),
        .fifo_flush   (fifo_flush),
        .bb_col       (bb_col)
    );

endmodule

// File: design/mm_regs.sv
`timescale 1ns/1ns

module mm_regs
    import img_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        s_chipselect,
    input  logic        s_read,
    input  logic        s_write,
    input  reg_addr_t   s_address,
    input  word_t       s_writedata,
    output word_t       s_readdata,
    input  word_t       fifo_head,
    input  fifo_level_t fifo_level,
    input  logic        fifo_empty,
    output logic        fifo_rd,
    output logic        fifo_flush,
    output pixel_t      bb_col
);

    logic [7:0] reg_status;
    logic       rd_strobe;
    logic       wr_strobe;
    logic       rd_strobe_d;

    assign rd_strobe = s_chipselect & s_read;
    assign wr_strobe = s_chipselect & s_write;

    ////////////////////////////////////////////////////////////////////////////
    // writes

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            reg_status <= '0;
            bb_col     <= BB_COL_DEFAULT;
        end else if (wr_strobe) begin
            if (s_address == ADDR_STATUS) begin
                reg_status <= s_writedata[7:0];
            end
            if (s_address == ADDR_BBCOL) begin
                bb_col <= s_writedata[23:0];
            end
        end
    end

    assign fifo_flush = wr_strobe & (s_address == ADDR_STATUS) & s_writedata[FLUSH_BIT];

    ////////////////////////////////////////////////////////////////////////////
    // reads

    // pop once per read strobe, on its first cycle
    assign fifo_rd = rd_strobe & ~rd_strobe_d & ~fifo_empty & (s_address == ADDR_MSG);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            s_readdata  <= '0;
            rd_strobe_d <= 1'b0;
        end else begin
            rd_strobe_d <= rd_strobe;
            if (rd_strobe) begin
                case (s_address)
                    ADDR_STATUS: s_readdata <= {16'b0, fifo_level, reg_status};
                    ADDR_MSG:    s_readdata <= fifo_head;
                    ADDR_ID:     s_readdata <= DEVICE_ID;
                    ADDR_BBCOL:  s_readdata <= {8'b0, bb_col};
                    default:     s_readdata <= '0;
                endcase
            end
        end
    end

endmodule

// File: design/msg_fifo.sv
`timescale 1ns/1ns

module msg_fifo
    import img_pkg::*;
#(
    parameter int FIFO_DEPTH = 255
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        flush,
    input  logic        wr,
    input  logic        rd,
    input  word_t       wr_data,
    output word_t       head,
    output fifo_level_t level,
    output logic        empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    word_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic             full;
    logic             do_wr, do_rd;

    // wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign empty = (level == '0);
    assign full  = (level == fifo_level_t'(FIFO_DEPTH));
    assign do_wr = wr & ~full;
    assign do_rd = rd & ~empty;

    // show-ahead head, reads zero when empty
    assign head = empty ? '0 : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!reset_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   level <= level + fifo_level_t'(1);
                2'b01:   level <= level - fifo_level_t'(1);
                default: level <= level;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// File: design/msg_writer.sv
`timescale 1ns/1ns

module msg_writer
    import img_pkg::*;
#(
    parameter int MSG_INTERVAL = 30,
    parameter int FIFO_DEPTH   = 255
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        frame_end,
    input  coord_t      left,
    input  coord_t      right,
    input  coord_t      top,
    input  coord_t      bottom,
    input  count_t      bright_count,
    input  fifo_level_t fifo_level,
    output logic        fifo_wr,
    output word_t       fifo_data
);

    localparam int CNT_W = $clog2(MSG_INTERVAL + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ID,
        ST_CENTRE,
        ST_SIZE,
        ST_COUNT
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] frame_cnt;
    logic             room;
    logic             start;
    logic [11:0]      sum_x, sum_y;
    coord_t           width, height;

    // room for a whole message
    assign room  = fifo_level <= fifo_level_t'(FIFO_DEPTH - MSG_WORDS);
    assign start = frame_end && (frame_cnt == '0) && room && (state == ST_IDLE);

    // countdown waits at zero until a message fits
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            frame_cnt <= '0;
        end else if (start) begin
            frame_cnt <= CNT_W'(MSG_INTERVAL - 1);
        end else if (frame_end && frame_cnt != '0) begin
            frame_cnt <= frame_cnt - CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_ID;
                    end
                end
                ST_ID:     state <= ST_CENTRE;
                ST_CENTRE: state <= ST_SIZE;
                ST_SIZE:   state <= ST_COUNT;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // message words

    assign sum_x  = {1'b0, left} + {1'b0, right};
    assign sum_y  = {1'b0, top} + {1'b0, bottom};
    assign width  = right - left;
    assign height = bottom - top;

    assign fifo_wr = (state != ST_IDLE);

    always_comb begin
        case (state)
            ST_ID:     fifo_data = MSG_ID_WORD;
            ST_CENTRE: fifo_data = {5'b0, sum_x[11:1], 5'b0, sum_y[11:1]};
            ST_SIZE:   fifo_data = {5'b0, height, 5'b0, width};
            ST_COUNT:  fifo_data = {12'b0, bright_count};
            default:   fifo_data = '0;
        endcase
    end

endmodule

// File: design/overlay_mixer.sv
`timescale 1ns/1ns

module overlay_mixer
    import img_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  pixel_t sink_data,
    input  logic   sink_valid,
    input  logic   sink_sop,
    input  logic   sink_eop,
    input  logic   overlay_mode,
    input  logic   pixel_en,
    input  coord_t x,
    input  coord_t y,
    input  coord_t left,
    input  coord_t right,
    input  coord_t top,
    input  coord_t bottom,
    input  pixel_t bb_col,
    output logic   bright,
    output logic   sink_ready,
    output pixel_t source_data,
    output logic   source_valid,
    output logic   source_sop,
    output logic   source_eop,
    input  logic   source_ready
);

    logic [7:0] red, green, blue, grey;
    logic       on_edge;
    logic       load;
    pixel_t     mixed;

    assign {red, green, blue} = sink_data;

    // max channel >= 128 is the same as any channel having bit 7 set
    assign bright  = red[7] | green[7] | blue[7];
    assign grey    = green[7:1] + red[7:2] + blue[7:2];
    assign on_edge = (x == left) | (x == right) | (y == top) | (y == bottom);

    always_comb begin
        mixed = sink_data;
        if (overlay_mode && pixel_en) begin
            if (on_edge) begin
                mixed = bb_col;
            end else if (bright) begin
                mixed = BRIGHT_COL;
            end else begin
                mixed = {grey, grey, grey};
            end
        end
    end

    // one-beat output register
    assign sink_ready = ~source_valid | source_ready;
    assign load       = sink_valid & sink_ready;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            source_valid <= 1'b0;
        end else if (sink_ready) begin
            source_valid <= sink_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            source_data <= mixed;
            source_sop  <= sink_sop;
            source_eop  <= sink_eop;
        end
    end

endmodule

// File: design/box_tracker.sv
`timescale 1ns/1ns

module box_tracker
    import img_pkg::*;
#(
    parameter int IMAGE_W = 640,
    parameter int IMAGE_H = 480
) (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   accept,
    input  logic   sop,
    input  logic   pixel_en,
    input  logic   bright,
    input  logic   frame_end,
    input  coord_t x,
    input  coord_t y,
    output coord_t left,
    output coord_t right,
    output coord_t top,
    output coord_t bottom,
    output count_t bright_count
);

    localparam coord_t X_LAST = coord_t'(IMAGE_W - 1);
    localparam coord_t Y_LAST = coord_t'(IMAGE_H - 1);

    coord_t x_min, x_max, y_min, y_max;
    count_t count;
    coord_t x_min_nxt, x_max_nxt, y_min_nxt, y_max_nxt;
    count_t count_nxt;
    logic   hit;

    assign hit = pixel_en & bright;

    // running extremes including the current beat
    assign x_min_nxt = (hit && x < x_min) ? x : x_min;
    assign x_max_nxt = (hit && x > x_max) ? x : x_max;
    assign y_min_nxt = (hit && y < y_min) ? y : y_min;
    assign y_max_nxt = (hit && y > y_max) ? y : y_max;
    assign count_nxt = hit ? count + count_t'(1) : count;

    always_ff @(posedge clk) begin
        if (!reset_n || (accept && sop)) begin
            x_min <= X_LAST;
            x_max <= '0;
            y_min <= Y_LAST;
            y_max <= '0;
            count <= '0;
        end else begin
            x_min <= x_min_nxt;
            x_max <= x_max_nxt;
            y_min <= y_min_nxt;
            y_max <= y_max_nxt;
            count <= count_nxt;
        end
    end

    // box of the finished frame, the eop pixel is counted too
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            left         <= X_LAST;
            right        <= '0;
            top          <= Y_LAST;
            bottom       <= '0;
            bright_count <= '0;
        end else if (frame_end) begin
            left         <= x_min_nxt;
            right        <= x_max_nxt;
            top          <= y_min_nxt;
            bottom       <= y_max_nxt;
            bright_count <= count_nxt;
        end
    end

endmodule

// File: design/pixel_counter.sv
`timescale 1ns/1ns

module pixel_counter
    import img_pkg::*;
#(
    parameter int IMAGE_W = 640
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       accept,
    input  logic       sop,
    input  logic       eop,
    input  logic [7:0] descriptor_blue,
    output coord_t     x,
    output coord_t     y,
    output logic       video_pkt,
    output logic       pixel_en,
    output logic       frame_end
);

    localparam coord_t X_LAST = coord_t'(IMAGE_W - 1);

    // the descriptor beat itself is never a pixel
    assign pixel_en  = accept & ~sop & video_pkt;

    // last picture beat of a video packet
    assign frame_end = pixel_en & eop;

    // x, y name the beat being accepted now
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            x         <= '0;
            y         <= '0;
            video_pkt <= 1'b0;
        end else if (accept && sop) begin
            x         <= '0;
            y         <= '0;
            // video packet when the low nibble of blue is zero
            video_pkt <= (descriptor_blue[3:0] == 4'h0);
        end else if (pixel_en) begin
            if (x == X_LAST) begin
                x <= '0;
                y <= y + coord_t'(1);
            end else begin
                x <= x + coord_t'(1);
            end
        end
    end

endmodule

// File: design/img_pkg.sv
package img_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths

    typedef logic [23:0] pixel_t;
    typedef logic [10:0] coord_t;
    typedef logic [19:0] count_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  fifo_level_t;
    typedef logic [2:0]  reg_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // host register map

    localparam reg_addr_t ADDR_STATUS = 3'd0;
    localparam reg_addr_t ADDR_MSG    = 3'd1;
    localparam reg_addr_t ADDR_ID     = 3'd2;
    localparam reg_addr_t ADDR_BBCOL  = 3'd3;

    // status bit 4 flushes the message FIFO on write
    localparam int FLUSH_BIT = 4;

    localparam word_t DEVICE_ID = 32'h1234_EEE2;

    ////////////////////////////////////////////////////////////////////////////
    // message and colour constants

    // ascii "RBB"
    localparam word_t  MSG_ID_WORD    = 32'h0052_4242;
    localparam int     MSG_WORDS      = 4;
    localparam pixel_t BB_COL_DEFAULT = 24'h00_ff_00;
    localparam pixel_t BRIGHT_COL     = 24'hff_00_00;

endpackage
